// ==== Bender.yml ====
package:
  name: if_stage

sources:
  - include_dirs:
      - include
    files:
      - design/fetch_pkg.sv
      - design/fetch_word_queue.sv
      - design/prefetch_unit.sv
      - design/rvc_expander.sv
      - design/if_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_clk_gen.sv
      - verif/if_stage_props.sv
      - verif/if_stage_tb.sv

// ==== design/fetch_pkg.sv ====
// fetch stage shared types
// pc and exception selects, vector offsets, queue count type and
// the rv32i opcodes that the rvc expander produces

`include "fetch_cfg.svh"

package fetch_pkg;

  // next fetch address source
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_EXCEPTION = 3'd2,
    PC_ERET      = 3'd3,
    PC_DBG_NPC   = 3'd4
  } pc_sel_e;

  // exception vector source
  typedef enum logic [1:0] {
    EXC_PC_ILLINSN = 2'd0,
    EXC_PC_ECALL   = 2'd1,
    EXC_PC_IRQ     = 2'd2
  } exc_sel_e;

  // low byte of the handler address, upper bits come from boot_addr
  localparam logic [7:0] EXC_OFF_RST     = 8'h80;
  localparam logic [7:0] EXC_OFF_ILLINSN = 8'h84;
  localparam logic [7:0] EXC_OFF_ECALL   = 8'h88;

  // word count, wide enough to hold a full queue
  typedef logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0] qcnt_t;

  // rv32i major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL    = 7'h6f;

endpackage

// ==== design/fetch_word_queue.sv ====
// fetch word queue
// buffers fetched words and presents one instruction window at the
// current pc, which may sit on any halfword

`timescale 1ns/10ps
`include "fetch_cfg.svh"

module fetch_word_queue (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     branch_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
  input  logic                     wr_valid_i,
  input  logic [31:0]              wr_data_i,
  input  logic                     ready_i,
  output logic                     valid_o,
  output logic [31:0]              rdata_o,
  output logic [`FETCH_ADDR_W-1:0] addr_o,
  output fetch_pkg::qcnt_t         occupancy_o,
  output logic                     empty_o
);

  import fetch_pkg::*;

  localparam int DEPTH = `FETCH_QUEUE_DEPTH;
  localparam int PW    = $clog2(DEPTH);

  logic [31:0]              mem_q [DEPTH];
  logic [PW-1:0]            rptr_q, wptr_q, rptr_nx;
  qcnt_t                    cnt_q;
  logic [`FETCH_ADDR_W-1:0] addr_q;
  logic [31:0]              word0, word1;
  logic                     compr, pop, free;

  // ---------------------------------------------------------------------------
  // instruction window
  // ---------------------------------------------------------------------------
  assign rptr_nx = rptr_q + 1'b1;
  assign word0   = mem_q[rptr_q];
  assign word1   = mem_q[rptr_nx];

  // odd halfword pc takes the upper half of the head word and the lower
  // half of the next one
  assign rdata_o = addr_q[1] ? {word1[15:0], word0[31:16]} : word0;
  assign compr   = (rdata_o[1:0] != 2'b11);

  // a misaligned 32-bit instruction needs two words in the queue
  assign valid_o = (cnt_q != '0) && (!addr_q[1] || compr || (cnt_q > 1));

  assign pop  = ready_i & valid_o;
  // head word is used up unless a compressed insn leaves its upper half
  assign free = pop & (addr_q[1] | ~compr);

  assign addr_o      = addr_q;
  assign occupancy_o = cnt_q;
  assign empty_o     = (cnt_q == '0);

  // ---------------------------------------------------------------------------
  // pointers, count and pc
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rptr_q <= '0;
      wptr_q <= '0;
      cnt_q  <= '0;
      addr_q <= '0;
    end else if (branch_i) begin
      // flush, keep bit 1 so the first halfword can be skipped
      rptr_q <= '0;
      wptr_q <= '0;
      cnt_q  <= '0;
      addr_q <= {branch_addr_i[`FETCH_ADDR_W-1:1], 1'b0};
    end else begin
      if (wr_valid_i) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (free) begin
        rptr_q <= rptr_nx;
      end
      if (pop) begin
        addr_q <= addr_q + (compr ? `FETCH_ADDR_W'(2) : `FETCH_ADDR_W'(4));
      end
      cnt_q <= cnt_q + qcnt_t'(wr_valid_i) - qcnt_t'(free);
    end
  end

  // word storage
  always_ff @(posedge clk) begin
    if (wr_valid_i && !branch_i) begin
      mem_q[wptr_q] <= wr_data_i;
    end
  end

endmodule

// ==== design/if_stage.sv ====
// instruction fetch stage
// next pc selection, prefetching, rvc expansion and the if/id
// pipeline register

`timescale 1ns/10ps
`include "fetch_cfg.svh"

module if_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`FETCH_ADDR_W-1:0] boot_addr_i,
  input  logic                     req_i,
  // instruction memory
  output logic                     instr_req_o,
  output logic [`FETCH_ADDR_W-1:0] instr_addr_o,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  logic [31:0]              instr_rdata_i,
  // if/id register towards decode
  output logic                     instr_valid_id_o,
  output logic [31:0]              instr_rdata_id_o,
  output logic                     is_compressed_id_o,
  output logic                     illegal_c_insn_id_o,
  output logic [`FETCH_ADDR_W-1:0] pc_if_o,
  output logic [`FETCH_ADDR_W-1:0] pc_id_o,
  // control from decode and the controller
  input  logic                     clear_instr_valid_i,
  input  logic                     pc_set_i,
  input  logic [`FETCH_ADDR_W-1:0] exception_pc_reg_i,
  input  fetch_pkg::pc_sel_e       pc_mux_i,
  input  fetch_pkg::exc_sel_e      exc_pc_mux_i,
  input  logic [4:0]               exc_vec_pc_mux_i,
  input  logic [`FETCH_ADDR_W-1:0] jump_target_ex_i,
  input  logic [`FETCH_ADDR_W-1:0] dbg_jump_addr_i,
  input  logic                     halt_if_i,
  input  logic                     id_ready_i,
  output logic                     if_valid_o,
  output logic                     if_busy_o,
  output logic                     perf_imiss_o
);

  import fetch_pkg::*;

  logic [`FETCH_ADDR_W-1:0] exc_pc, fetch_addr_n, fetch_addr;
  logic                     init_q, init_d;
  logic                     branch_req, valid;
  logic                     fetch_valid, fetch_ready;
  logic [31:0]              fetch_rdata, instr_exp;
  logic                     exp_compressed, exp_illegal;
  logic                     prefetch_busy;

  // ---------------------------------------------------------------------------
  // next pc
  // ---------------------------------------------------------------------------
  // handler address, low byte replaced on top of boot_addr
  always_comb begin
    exc_pc = '0;
    unique case (exc_pc_mux_i)
      EXC_PC_ILLINSN: exc_pc = {boot_addr_i[`FETCH_ADDR_W-1:8], EXC_OFF_ILLINSN};
      EXC_PC_ECALL:   exc_pc = {boot_addr_i[`FETCH_ADDR_W-1:8], EXC_OFF_ECALL};
      // vectored irq, one word per line
      EXC_PC_IRQ:     exc_pc = {boot_addr_i[`FETCH_ADDR_W-1:8], 1'b0,
                                exc_vec_pc_mux_i, 2'b00};
      default: ;
    endcase
  end

  always_comb begin
    fetch_addr_n = '0;
    unique case (pc_mux_i)
      PC_BOOT:      fetch_addr_n = {boot_addr_i[`FETCH_ADDR_W-1:8], EXC_OFF_RST};
      PC_JUMP:      fetch_addr_n = jump_target_ex_i;
      PC_EXCEPTION: fetch_addr_n = exc_pc;
      PC_ERET:      fetch_addr_n = exception_pc_reg_i;
      PC_DBG_NPC:   fetch_addr_n = dbg_jump_addr_i;
      default: ;
    endcase
  end

  prefetch_unit prefetch_unit_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_req),
    .branch_addr_i  ({fetch_addr_n[`FETCH_ADDR_W-1:1], 1'b0}),
    .ready_i        (fetch_ready),
    .valid_o        (fetch_valid),
    .rdata_o        (fetch_rdata),
    .addr_o         (fetch_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (prefetch_busy)
  );

  // ---------------------------------------------------------------------------
  // redirect control
  // ---------------------------------------------------------------------------
  // after reset wait for req_i, then redirect once to the boot pc
  always_comb begin
    init_d     = init_q;
    branch_req = 1'b0;
    valid      = 1'b0;
    if (init_q) begin
      if (req_i) begin
        branch_req = 1'b1;
        init_d     = 1'b0;
      end
    end else begin
      valid = fetch_valid;
    end
    // a pc_set always wins, the window at the old pc is dropped
    if (pc_set_i) begin
      valid      = 1'b0;
      branch_req = 1'b1;
      init_d     = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_q <= 1'b1;
    end else begin
      init_q <= init_d;
    end
  end

  assign if_valid_o   = valid & id_ready_i & ~halt_if_i;
  assign fetch_ready  = if_valid_o;
  assign pc_if_o      = fetch_addr;
  assign if_busy_o    = prefetch_busy;
  assign perf_imiss_o = ~fetch_valid | branch_req;

  rvc_expander rvc_expander_i (
    .instr_i         (fetch_rdata),
    .instr_o         (instr_exp),
    .is_compressed_o (exp_compressed),
    .illegal_instr_o (exp_illegal)
  );

  // ---------------------------------------------------------------------------
  // if/id register, frozen while decode stalls
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
    end else if (if_valid_o) begin
      instr_valid_id_o <= 1'b1;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid_o) begin
      instr_rdata_id_o    <= instr_exp;
      is_compressed_id_o  <= exp_compressed;
      illegal_c_insn_id_o <= exp_illegal;
      pc_id_o             <= fetch_addr;
    end
  end

endmodule

// ==== design/prefetch_unit.sv ====
// instruction prefetch unit
// issues req/gnt/rvalid word requests ahead of the pc, drops responses
// from before a redirect and feeds the word queue

`timescale 1ns/10ps
`include "fetch_cfg.svh"

module prefetch_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_i,
  input  logic                     branch_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
  input  logic                     ready_i,
  output logic                     valid_o,
  output logic [31:0]              rdata_o,
  output logic [`FETCH_ADDR_W-1:0] addr_o,
  output logic                     instr_req_o,
  output logic [`FETCH_ADDR_W-1:0] instr_addr_o,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  logic [31:0]              instr_rdata_i,
  output logic                     busy_o
);

  import fetch_pkg::*;

  logic [`FETCH_ADDR_W-1:0] addr_q, addr_d, br_addr_q, br_addr_d, br_word;
  logic                     br_pend_q, br_pend_d;
  logic                     en_q, hold_q;
  qcnt_t                    out_q, out_d, stale_q, stale_d, queue_occ;
  logic [3:0]               fill;
  logic                     issue, drop, wr_valid;

  fetch_word_queue word_queue_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .wr_valid_i    (wr_valid),
    .wr_data_i     (instr_rdata_i),
    .ready_i       (ready_i),
    .valid_o       (valid_o),
    .rdata_o       (rdata_o),
    .addr_o        (addr_o),
    .occupancy_o   (queue_occ),
    .empty_o       ()
  );

  // ---------------------------------------------------------------------------
  // request side
  // ---------------------------------------------------------------------------
  // every granted word must still fit once it lands
  assign fill = {1'b0, out_q} + {1'b0, queue_occ};

  // an ungranted request stays up, new ones only after the first redirect
  assign instr_req_o = hold_q |
                       (en_q & req_i & (out_q < `FETCH_MAX_OUTSTANDING) &
                        (fill < `FETCH_QUEUE_DEPTH));
  assign instr_addr_o = addr_q;
  assign issue        = instr_req_o & instr_gnt_i;
  assign br_word      = {branch_addr_i[`FETCH_ADDR_W-1:2], 2'b00};

  // responses from before the last redirect never reach the queue
  assign drop     = instr_rvalid_i & ((stale_q != '0) | branch_i);
  assign wr_valid = instr_rvalid_i & ~drop;
  assign busy_o   = instr_req_o | (out_q != '0);

  always_comb begin
    addr_d    = addr_q;
    br_addr_d = br_addr_q;
    br_pend_d = br_pend_q;
    out_d     = out_q + qcnt_t'(issue) - qcnt_t'(instr_rvalid_i);
    stale_d   = stale_q + qcnt_t'(issue & br_pend_q)
                - qcnt_t'(instr_rvalid_i & (stale_q != '0));

    if (branch_i) begin
      // everything in flight now belongs to the old stream
      stale_d = out_d;
      if (instr_req_o && !instr_gnt_i) begin
        // old address must stay on the bus until granted
        br_pend_d = 1'b1;
        br_addr_d = br_word;
      end else begin
        br_pend_d = 1'b0;
        addr_d    = br_word;
      end
    end else if (issue) begin
      if (br_pend_q) begin
        br_pend_d = 1'b0;
        addr_d    = br_addr_q;
      end else begin
        addr_d = addr_q + `FETCH_ADDR_W'(4);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q    <= '0;
      br_addr_q <= '0;
      br_pend_q <= 1'b0;
      en_q      <= 1'b0;
      hold_q    <= 1'b0;
      out_q     <= '0;
      stale_q   <= '0;
    end else begin
      addr_q    <= addr_d;
      br_addr_q <= br_addr_d;
      br_pend_q <= br_pend_d;
      en_q      <= en_q | branch_i;
      hold_q    <= instr_req_o & ~instr_gnt_i;
      out_q     <= out_d;
      stale_q   <= stale_d;
    end
  end

endmodule

// ==== design/rvc_expander.sv ====
// compressed instruction expander
// maps a subset of rvc to rv32i, other 16-bit encodings are flagged
// illegal and passed through

`timescale 1ns/10ps

module rvc_expander (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_instr_o
);

  import fetch_pkg::*;

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    // 32-bit and unsupported encodings pass through unchanged
    instr_o         = instr_i;
    illegal_instr_o = 1'b0;

    unique case (instr_i[1:0])
      // -----------------------------------------------------------------------
      // quadrant 0, rd'/rs1'/rs2' select x8..x15
      // -----------------------------------------------------------------------
      2'b00: begin
        unique case (instr_i[15:13])
          3'b010: begin
            // c.lw -> lw rd', uimm(rs1')
            instr_o = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                       2'b01, instr_i[9:7], 3'b010, 2'b01, instr_i[4:2], OPC_LOAD};
          end
          3'b110: begin
            // c.sw -> sw rs2', uimm(rs1')
            instr_o = {5'b0, instr_i[5], instr_i[12], 2'b01, instr_i[4:2],
                       2'b01, instr_i[9:7], 3'b010, instr_i[11:10], instr_i[6],
                       2'b00, OPC_STORE};
          end
          default: illegal_instr_o = 1'b1;
        endcase
      end

      // -----------------------------------------------------------------------
      // quadrant 1
      // -----------------------------------------------------------------------
      2'b01: begin
        unique case (instr_i[15:13])
          3'b000: begin
            // c.addi, c.nop is rd = x0
            instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7],
                       3'b000, instr_i[11:7], OPC_OP_IMM};
          end
          3'b010: begin
            // c.li -> addi rd, x0, imm
            instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 5'b0,
                       3'b000, instr_i[11:7], OPC_OP_IMM};
          end
          3'b011: begin
            // c.lui, rd = x2 would be c.addi16sp
            instr_o = {{15{instr_i[12]}}, instr_i[6:2], instr_i[11:7], OPC_LUI};
            if (instr_i[11:7] == 5'd2 || {instr_i[12], instr_i[6:2]} == 6'b0) begin
              illegal_instr_o = 1'b1;
              instr_o         = instr_i;
            end
          end
          3'b101: begin
            // c.j -> jal x0, offset
            instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                       instr_i[7], instr_i[2], instr_i[11], instr_i[5:3],
                       instr_i[12], {8{instr_i[12]}}, 5'b0, OPC_JAL};
          end
          3'b110, 3'b111: begin
            // c.beqz / c.bnez, funct3 low bit comes from bit 13
            instr_o = {instr_i[12], {3{instr_i[12]}}, instr_i[6:5], instr_i[2],
                       5'b0, 2'b01, instr_i[9:7], 2'b00, instr_i[13],
                       instr_i[11:10], instr_i[4:3], instr_i[12], OPC_BRANCH};
          end
          default: illegal_instr_o = 1'b1;
        endcase
      end

      // -----------------------------------------------------------------------
      // quadrant 2, only c.mv and c.add
      // -----------------------------------------------------------------------
      2'b10: begin
        if (instr_i[15:13] == 3'b100 && instr_i[6:2] != 5'b0) begin
          // bit 12 picks c.add (rd + rs2) over c.mv (x0 + rs2)
          instr_o = {7'b0, instr_i[6:2], instr_i[12] ? instr_i[11:7] : 5'b0,
                     3'b000, instr_i[11:7], OPC_OP};
        end else begin
          illegal_instr_o = 1'b1;
        end
      end

      default: ;
    endcase
  end

endmodule

// ==== include/fetch_cfg.svh ====
// fetch stage configuration
// address width, word queue depth and memory request limit

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// instruction address width
`define FETCH_ADDR_W 32

// word entries in the fetch queue, power of two
`define FETCH_QUEUE_DEPTH 4

// granted requests still waiting for rvalid
`define FETCH_MAX_OUTSTANDING 2

`endif

// ==== project.f ====
+incdir+include
design/fetch_pkg.sv
design/fetch_word_queue.sv
design/prefetch_unit.sv
design/rvc_expander.sv
design/if_stage.sv
verif/tb_clk_gen.sv
verif/if_stage_props.sv
verif/if_stage_tb.sv

// ==== verif/if_stage_props.sv ====
// fetch stage interface properties
// memory handshake rules, request limit and reset values

`timescale 1ns/10ps
`include "fetch_cfg.svh"

module if_stage_props (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     instr_req_o,
  input logic [`FETCH_ADDR_W-1:0] instr_addr_o,
  input logic                     instr_gnt_i,
  input logic                     instr_rvalid_i,
  input logic                     instr_valid_id_o,
  input logic                     if_valid_o
);

  // granted requests still waiting for rvalid
  int outstanding;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(instr_req_o & instr_gnt_i) - int'(instr_rvalid_i);
    end
  end

  gnt_only_with_req: assert property (@(posedge clk) disable iff (!rst_n)
    instr_gnt_i |-> instr_req_o)
    else $error("instr_gnt_i high without a pending request");

  addr_stable_until_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_addr_o == $past(instr_addr_o))
    else $error("instr_addr_o changed before its grant");

  outstanding_limit: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= `FETCH_MAX_OUTSTANDING)
    else $error("too many outstanding memory requests");

  quiet_in_reset: assert property (@(posedge clk)
    !rst_n |-> !instr_req_o && !instr_valid_id_o && !if_valid_o)
    else $error("fetch outputs active during reset");

endmodule

// ==== verif/if_stage_tb.sv ====
// fetch stage testbench
// memory model with random delays, redirect and stall stimulus,
// in-order reference of the expected pc stream

`timescale 1ns/10ps
`include "fetch_cfg.svh"

module if_stage_tb;

  import fetch_pkg::*;

  localparam int          NUM_TESTS = 5;
  localparam logic [31:0] BOOT_ADDR = 32'h0000_1000;
  localparam logic [31:0] BOOT_PC   = {BOOT_ADDR[31:8], EXC_OFF_RST};

  logic        clk, rst_n;
  logic [31:0] boot_addr_i, instr_addr_o, instr_rdata_id_o;
  logic [31:0] pc_if_o, pc_id_o, exception_pc_reg_i, jump_target_ex_i, dbg_jump_addr_i;
  logic        req_i, instr_req_o;
  logic        instr_valid_id_o, is_compressed_id_o, illegal_c_insn_id_o;
  logic        clear_instr_valid_i, pc_set_i, halt_if_i, id_ready_i;
  logic        if_valid_o, if_busy_o, perf_imiss_o;
  pc_sel_e     pc_mux_i;
  exc_sel_e    exc_pc_mux_i;
  logic [4:0]  exc_vec_pc_mux_i;
  // memory side inputs, idle from time zero
  logic        instr_gnt_i    = 1'b0;
  logic        instr_rvalid_i = 1'b0;
  logic [31:0] instr_rdata_i  = '0;

  // program image, 1 KB aliased over the whole address space
  logic [15:0] half_q [512];
  logic [31:0] exp_instr [512];
  logic [31:0] exp_mask [512];
  logic        exp_c [512];
  logic        exp_ill [512];
  logic        is_start [512];
  // instruction menu with hand-expanded rv32i forms
  logic [31:0] ins_val [14];
  logic [31:0] ins_exp [14];
  logic        ins_ill [14];

  logic [31:0] lcg_state, exp_pc, redirect_pc;
  logic        load_pend, clr_pend, first_gnt;
  logic [31:0] rsp_data [$];
  int          rsp_due [$];
  int          errors, tests_failed, load_cnt, cyc, gnt_wait, last_due;

  tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  if_stage if_stage_i (.*);

  bind if_stage if_stage_props props_i (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'b0, lcg_state[30:16]};
  endfunction

  task automatic set_ins(input int k, input logic [31:0] val, input logic [31:0] exp,
                         input logic ill);
    ins_val[k] = val;
    ins_exp[k] = exp;
    ins_ill[k] = ill;
  endtask

  // lower 256 bytes hold only 16-bit code so every vector is an instruction start
  task automatic build_program();
    int h;
    int k;
    set_ins(0, 32'h0415, 32'h0054_0413, 1'b0);   // c.addi x8, 5
    set_ins(1, 32'h557d, 32'hfff0_0513, 1'b0);   // c.li x10, -1
    set_ins(2, 32'h6485, 32'h0000_14b7, 1'b0);   // c.lui x9, 1
    set_ins(3, 32'h85b2, 32'h00c0_05b3, 1'b0);   // c.mv x11, x12
    set_ins(4, 32'h96ba, 32'h00e6_86b3, 1'b0);   // c.add x13, x14
    set_ins(5, 32'h4144, 32'h0045_2483, 1'b0);   // c.lw x9, 4(x10)
    set_ins(6, 32'hc60c, 32'h00b6_2423, 1'b0);   // c.sw x11, 8(x12)
    set_ins(7, 32'ha011, 32'h0040_006f, 1'b0);   // c.j 4
    set_ins(8, 32'hc401, 32'h0004_0463, 1'b0);   // c.beqz x8, 8
    set_ins(9, 32'he089, 32'h0004_9163, 1'b0);   // c.bnez x9, 2
    set_ins(10, 32'h0000, 32'h0000_0000, 1'b1);  // reserved
    set_ins(11, 32'h8002, 32'h0000_8002, 1'b1);  // c.jr, not supported
    set_ins(12, 32'h0031_0093, 32'h0031_0093, 1'b0);
    set_ins(13, 32'h0003_2283, 32'h0003_2283, 1'b0);
    h = 0;
    while (h < 512) begin
      k = (h < 128) ? int'(lcg_next() % 12) : int'(lcg_next() % 14);
      if (k >= 12 && h == 511) begin
        k = 0;
      end
      is_start[h]  = 1'b1;
      exp_instr[h] = ins_exp[k];
      exp_ill[h]   = ins_ill[k];
      exp_mask[h]  = ins_ill[k] ? 32'h0000_ffff : 32'hffff_ffff;
      exp_c[h]     = (ins_val[k][1:0] != 2'b11);
      half_q[h]    = ins_val[k][15:0];
      if (k >= 12) begin
        half_q[h+1]   = ins_val[k][31:16];
        is_start[h+1] = 1'b0;
        h = h + 2;
      end else begin
        h = h + 1;
      end
    end
  endtask

  // ---------------------------------------------------------------------------
  // memory model
  // ---------------------------------------------------------------------------
  // grant is registered, it comes one to four cycles after the request rises
  always @(posedge clk or negedge rst_n) begin
    int w;
    int due;
    if (!rst_n) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      instr_rdata_i  <= '0;
      cyc      = 0;
      gnt_wait = 0;
      last_due = 0;
    end else begin
      cyc = cyc + 1;
      if (instr_req_o && instr_gnt_i) begin
        assert (first_gnt || instr_addr_o == BOOT_PC)
        else begin
          $display("MISMATCH at %0t: instr_addr_o expected %h actual %h",
                   $time, BOOT_PC, instr_addr_o);
          errors++;
        end
        first_gnt = 1'b1;
        w   = int'(instr_addr_o[9:2]);
        due = cyc + int'(lcg_next() % 4);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_data.push_back({half_q[2*w+1], half_q[2*w]});
        rsp_due.push_back(due);
        gnt_wait = int'(lcg_next() % 4);
        instr_gnt_i <= 1'b0;
      end else if (instr_req_o && gnt_wait > 0) begin
        gnt_wait--;
        instr_gnt_i <= 1'b0;
      end else begin
        instr_gnt_i <= instr_req_o;
      end
      if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= rsp_data.pop_front();
        void'(rsp_due.pop_front());
      end else begin
        instr_rvalid_i <= 1'b0;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // if/id checks, sampled mid-cycle
  // ---------------------------------------------------------------------------
  always @(negedge clk) begin
    int   idx;
    logic busy_exp;
    if (rst_n) begin
      idx = int'(exp_pc[9:1]);
      if (load_pend) begin
        assert (pc_id_o == exp_pc)
        else begin
          $display("MISMATCH at %0t: pc_id_o expected %h actual %h", $time, exp_pc, pc_id_o);
          errors++;
        end
        assert ((instr_rdata_id_o & exp_mask[idx]) == (exp_instr[idx] & exp_mask[idx]))
        else begin
          $display("MISMATCH at %0t: instr_rdata_id_o expected %h actual %h",
                   $time, exp_instr[idx], instr_rdata_id_o);
          errors++;
        end
        assert (is_compressed_id_o == exp_c[idx])
        else begin
          $display("MISMATCH at %0t: is_compressed_id_o expected %b actual %b",
                   $time, exp_c[idx], is_compressed_id_o);
          errors++;
        end
        assert (illegal_c_insn_id_o == exp_ill[idx])
        else begin
          $display("MISMATCH at %0t: illegal_c_insn_id_o expected %b actual %b",
                   $time, exp_ill[idx], illegal_c_insn_id_o);
          errors++;
        end
        exp_pc   = exp_pc + (exp_c[idx] ? 32'd2 : 32'd4);
        load_cnt = load_cnt + 1;
      end
      if (load_pend || clr_pend) begin
        assert (instr_valid_id_o == load_pend)
        else begin
          $display("MISMATCH at %0t: instr_valid_id_o expected %b actual %b",
                   $time, load_pend, instr_valid_id_o);
          errors++;
        end
      end
      if (pc_set_i) begin
        exp_pc = redirect_pc;
      end
      // the window about to load sits at the next expected pc
      if (if_valid_o) begin
        assert (pc_if_o == exp_pc)
        else begin
          $display("MISMATCH at %0t: pc_if_o expected %h actual %h", $time, exp_pc, pc_if_o);
          errors++;
        end
      end
      // decode is willing, so a cycle without a load is a miss
      if (pc_set_i || (id_ready_i && !halt_if_i)) begin
        assert (perf_imiss_o == !if_valid_o)
        else begin
          $display("MISMATCH at %0t: perf_imiss_o expected %b actual %b",
                   $time, !if_valid_o, perf_imiss_o);
          errors++;
        end
      end
      // busy while a request waits or a granted word has not come back
      busy_exp = instr_req_o || instr_rvalid_i || (rsp_due.size() > 0);
      assert (if_busy_o == busy_exp)
      else begin
        $display("MISMATCH at %0t: if_busy_o expected %b actual %b",
                 $time, busy_exp, if_busy_o);
        errors++;
      end
      load_pend = if_valid_o;
      clr_pend  = clear_instr_valid_i & ~if_valid_o;
    end
  end

  // the register holds while nothing loads
  assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_id_o && !if_valid_o |=> $stable(pc_id_o) && $stable(instr_rdata_id_o))
  else begin
    $display("%0t: IF/ID register changed while no instruction was loaded", $time);
    errors++;
  end

  task automatic wait_loads(input int n);
    int target;
    target = load_cnt + n;
    while (load_cnt < target) begin
      @(posedge clk);
    end
  endtask

  task automatic redirect(input pc_sel_e sel, input exc_sel_e esel, input logic [4:0] vec,
                          input logic [31:0] target);
    @(posedge clk);
    pc_mux_i           <= sel;
    exc_pc_mux_i       <= esel;
    exc_vec_pc_mux_i   <= vec;
    jump_target_ex_i   <= (sel == PC_JUMP) ? target : lcg_next();
    exception_pc_reg_i <= (sel == PC_ERET) ? target : lcg_next();
    dbg_jump_addr_i    <= (sel == PC_DBG_NPC) ? target : lcg_next();
    pc_set_i           <= 1'b1;
    redirect_pc = target;
    @(posedge clk);
    pc_set_i <= 1'b0;
  endtask

  // random instruction start in the mixed 16/32-bit area
  function automatic logic [31:0] pick_start();
    int          h;
    logic [31:0] upper;
    h = 128 + int'(lcg_next() % 384);
    while (!is_start[h]) begin
      h = (h + 1) % 512;
    end
    upper = (lcg_next() % 16) << 12;
    return upper + 32'(h * 2);
  endfunction

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: fail with %0d errors", name, errors - err_before);
      tests_failed++;
    end
  endtask

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  initial begin
    int          e0;
    logic [4:0]  vec;
    pc_sel_e     sel;
    boot_addr_i         = BOOT_ADDR;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_ILLINSN;
    exc_vec_pc_mux_i    = '0;
    jump_target_ex_i    = '0;
    exception_pc_reg_i  = '0;
    dbg_jump_addr_i     = '0;
    halt_if_i           = 1'b0;
    id_ready_i          = 1'b1;
    clear_instr_valid_i = 1'b0;
    lcg_state    = 32'd97636;
    errors       = 0;
    tests_failed = 0;
    load_cnt     = 0;
    load_pend    = 1'b0;
    clr_pend     = 1'b0;
    first_gnt    = 1'b0;
    exp_pc       = BOOT_PC;
    redirect_pc  = BOOT_PC;
    build_program();
    @(posedge rst_n);

    e0 = errors;
    @(posedge clk);
    req_i <= 1'b1;
    wait_loads(1);
    finish_test("boot", e0);

    e0 = errors;
    wait_loads(250);
    finish_test("sequential stream", e0);

    e0 = errors;
    for (int i = 0; i < 9; i++) begin
      sel = (i % 3 == 0) ? PC_JUMP : (i % 3 == 1) ? PC_ERET : PC_DBG_NPC;
      redirect(sel, EXC_PC_ILLINSN, 5'd0, pick_start());
      wait_loads(12);
    end
    finish_test("redirects", e0);

    e0 = errors;
    redirect(PC_EXCEPTION, EXC_PC_ILLINSN, 5'd0, {BOOT_ADDR[31:8], EXC_OFF_ILLINSN});
    wait_loads(6);
    redirect(PC_EXCEPTION, EXC_PC_ECALL, 5'd0, {BOOT_ADDR[31:8], EXC_OFF_ECALL});
    wait_loads(6);
    for (int i = 0; i < 4; i++) begin
      vec = 5'(lcg_next() % 32);
      redirect(PC_EXCEPTION, EXC_PC_IRQ, vec, {BOOT_ADDR[31:8], 8'h00} + 32'(vec) * 4);
      wait_loads(6);
    end
    finish_test("exception vectors", e0);

    e0 = errors;
    for (int i = 0; i < 80; i++) begin
      @(posedge clk);
      id_ready_i          <= (lcg_next() % 2 == 0);
      halt_if_i           <= (lcg_next() % 3 == 0);
      clear_instr_valid_i <= (lcg_next() % 4 == 0);
    end
    @(posedge clk);
    id_ready_i          <= 1'b1;
    halt_if_i           <= 1'b0;
    clear_instr_valid_i <= 1'b0;
    wait_loads(30);
    finish_test("back-pressure", e0);

    $display("tests run %0d, failed %0d, check errors %0d", NUM_TESTS, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // run limit scaled with the number of tests
  initial begin
    #(NUM_TESTS * 2000 * 20);
    $display("timeout, the fetch stage stopped delivering instructions");
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== verif/tb_clk_gen.sv ====
// testbench clock and reset source
// 20 ns clock, reset held low for a fixed number of cycles

`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // release on a rising edge so the first active cycle is a full one
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule
